//--- Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --assert -j 0 -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_rap_top
FILELIST   = compile.f
PASS_MSG   = Done: no errors
SIM        = obj_dir/V$(TOP)

.PHONY: run build lint clean

# Default target builds and runs, exit status follows the pass line
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+logic
logic/rap_pkg.sv
logic/cf_classifier.sv
logic/sync_fifo.sv
logic/return_address_stack.sv
logic/return_predict_check.sv
logic/rap_top.sv
tb/tb_rap_top.sv

//--- logic/cf_classifier.sv
// Producer stage that turns retired JAL/JALR records into call, return and swap events
module cf_classifier (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  rap_pkg::instr_rec_t in_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    output rap_pkg::cf_event_t  out_o,
    output logic                out_valid_o,
    input  logic                out_ready_i
);

    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // Instruction fields
    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic       rd_link;
    logic       rs1_link;

    // Decode result
    logic              is_stack;
    rap_pkg::cf_kind_e kind;

    // Output register
    rap_pkg::cf_event_t out_q;
    logic               out_valid_q;

    logic in_fire;

    assign opcode = in_i.instr[6:0];
    assign rd     = in_i.instr[11:7];
    assign funct3 = in_i.instr[14:12];
    assign rs1    = in_i.instr[19:15];

    // x1 (ra) or x5 (t0) act as link registers
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    always_comb begin
        is_stack = 1'b0;
        kind     = rap_pkg::CF_CALL;
        if (opcode == OPC_JAL) begin
            is_stack = rd_link;  // Plain jumps drop out
        end else if (opcode == OPC_JALR && funct3 == 3'b000) begin
            if (rd_link && !rs1_link) begin
                is_stack = 1'b1;
            end else if (!rd_link && rs1_link) begin
                is_stack = 1'b1;
                kind     = rap_pkg::CF_RET;
            end else if (rd_link && rs1_link) begin
                is_stack = 1'b1;
                // Same register means a call, different means swap
                kind     = (rd == rs1) ? rap_pkg::CF_CALL : rap_pkg::CF_SWAP;
            end
        end
    end

    // Take a new record when empty or being drained
    assign in_ready_o = !out_valid_q || out_ready_i;
    assign in_fire    = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            out_valid_q <= 1'b0;
        end else if (in_fire) begin
            out_valid_q <= is_stack;  // Dropped records leave it empty
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Payload, no reset
    always_ff @(posedge clk_i) begin
        if (in_fire && is_stack) begin
            out_q.pc     <= in_i.pc;
            out_q.kind   <= kind;
            out_q.link   <= in_i.pc + rap_pkg::addr_t'(4);
            out_q.target <= in_i.target;
        end
    end

    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;

    // Stalled output must hold until the FIFO takes it
    a_out_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

//--- logic/rap_defs.svh
// Sizing macros for the return-address prediction unit, included by the package and the RTL
`ifndef RAP_DEFS_SVH
`define RAP_DEFS_SVH

// Return address stack sizing

// log2 of the stack entry count, 16 entries
`define RAP_RAS_LOG2 4

// Code address width
`define RAP_ADDR_W 40

// Event buffer sizing

// Entries in the classifier-to-checker FIFO
`define RAP_FIFO_DEPTH 4

`endif

//--- logic/rap_pkg.sv
// Shared record and event types for the return-address prediction unit and its testbench
`include "rap_defs.svh"

package rap_pkg;

    // Code address, same width as the stack entries
    typedef logic [`RAP_ADDR_W-1:0] addr_t;

    // Kind of stack event
    typedef enum logic [1:0] {
        CF_CALL = 2'd0,  // Push link address
        CF_RET  = 2'd1,  // Pop
        CF_SWAP = 2'd2   // Coroutine swap, pop then push
    } cf_kind_e;

    // Retired instruction as seen by the front end, 112 bits
    typedef struct packed {
        addr_t       pc;
        logic [31:0] instr;   // Raw 32-bit encoding
        addr_t       target;  // Next pc actually taken
    } instr_rec_t;

    // Stack-touching jump after classification, 122 bits
    typedef struct packed {
        addr_t    pc;
        cf_kind_e kind;
        addr_t    link;    // pc + 4
        addr_t    target;  // Resolved target, passed through
    } cf_event_t;

    // Scored prediction, 123 bits
    typedef struct packed {
        addr_t    pc;
        cf_kind_e kind;
        addr_t    pred;    // Predicted target
        addr_t    target;  // Resolved target
        logic     hit;     // pred == target, always set for calls
    } pred_res_t;

endpackage

//--- logic/rap_top.sv
// Top level of the return-address prediction unit, chains classifier, event FIFO and checker
module rap_top (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  rap_pkg::instr_rec_t instr_i,
    input  logic                instr_valid_i,
    output logic                instr_ready_o,
    output rap_pkg::pred_res_t  res_o,
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output logic [15:0]         ret_count_o,
    output logic [15:0]         hit_count_o
);

    // Classifier to FIFO
    rap_pkg::cf_event_t cls_ev;
    logic               cls_valid;
    logic               cls_ready;

    // FIFO to checker
    rap_pkg::cf_event_t fifo_ev;
    logic               fifo_valid;
    logic               fifo_ready;

    cf_classifier i_classifier (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_i        (instr_i),
        .in_valid_i  (instr_valid_i),
        .in_ready_o  (instr_ready_o),
        .out_o       (cls_ev),
        .out_valid_o (cls_valid),
        .out_ready_i (cls_ready)
    );

    sync_fifo #(
        .item_t (rap_pkg::cf_event_t)
    ) i_ev_fifo (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_data_i  (cls_ev),
        .wr_valid_i (cls_valid),
        .wr_ready_o (cls_ready),
        .rd_data_o  (fifo_ev),
        .rd_valid_o (fifo_valid),
        .rd_ready_i (fifo_ready)
    );

    return_predict_check i_checker (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .ev_i        (fifo_ev),
        .ev_valid_i  (fifo_valid),
        .ev_ready_o  (fifo_ready),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .ret_count_o (ret_count_o),
        .hit_count_o (hit_count_o)
    );

endmodule

//--- logic/return_address_stack.sv
// Circular return address stack with push, pop and replace-top, used by the prediction checker
`include "rap_defs.svh"

module return_address_stack (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  rap_pkg::addr_t push_addr_i,
    input  logic           push_i,
    input  logic           pop_i,
    output rap_pkg::addr_t return_address_o
);

    localparam int ENTRIES = 2 ** `RAP_RAS_LOG2;

    rap_pkg::addr_t            stack_q [ENTRIES];
    logic [`RAP_RAS_LOG2-1:0]  head_q;   // Next free slot
    logic [`RAP_RAS_LOG2-1:0]  top_ptr;  // Most recent entry

    // Wraps at both ends, overflow overwrites the oldest slot
    assign top_ptr = head_q - 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                stack_q[i] <= '0;
            end
        end else if (push_i && pop_i) begin
            stack_q[top_ptr] <= push_addr_i;  // Replace top, head stays
        end else if (push_i) begin
            stack_q[head_q] <= push_addr_i;
            head_q          <= head_q + 1'b1;
        end else if (pop_i) begin
            head_q <= top_ptr;
        end
    end

    assign return_address_o = stack_q[top_ptr];

endmodule

//--- logic/return_predict_check.sv
// Consumer stage that predicts return targets from the stack, scores them and keeps counters
module return_predict_check (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  rap_pkg::cf_event_t  ev_i,
    input  logic                ev_valid_i,
    output logic                ev_ready_o,
    output rap_pkg::pred_res_t  res_o,
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output logic [15:0]         ret_count_o,
    output logic [15:0]         hit_count_o
);

    logic           ev_fire;
    logic           ras_push;
    logic           ras_pop;
    rap_pkg::addr_t ras_top;   // Top before this edge's update

    rap_pkg::addr_t pred;
    logic           hit;
    logic           is_ret;    // Return or swap

    rap_pkg::pred_res_t res_q;
    logic               res_valid_q;
    logic [15:0]        ret_cnt_q;
    logic [15:0]        hit_cnt_q;

    assign ev_ready_o = !res_valid_q || res_ready_i;
    assign ev_fire    = ev_valid_i && ev_ready_o;

    // Kind to stack controls, swap does both
    assign ras_push = ev_fire && (ev_i.kind != rap_pkg::CF_RET);
    assign ras_pop  = ev_fire && (ev_i.kind != rap_pkg::CF_CALL);

    return_address_stack i_ras (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .push_addr_i      (ev_i.link),
        .push_i           (ras_push),
        .pop_i            (ras_pop),
        .return_address_o (ras_top)
    );

    assign is_ret = (ev_i.kind == rap_pkg::CF_RET) || (ev_i.kind == rap_pkg::CF_SWAP);

    // Calls are not predicted here, report their own target as a hit
    assign pred = is_ret ? ras_top : ev_i.target;
    assign hit  = is_ret ? (ras_top == ev_i.target) : 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            res_valid_q <= 1'b0;
            ret_cnt_q   <= '0;
            hit_cnt_q   <= '0;
        end else begin
            if (ev_fire) begin
                res_valid_q <= 1'b1;
            end else if (res_ready_i) begin
                res_valid_q <= 1'b0;
            end
            if (ev_fire && is_ret) begin
                ret_cnt_q <= ret_cnt_q + 1'b1;
                if (hit) begin
                    hit_cnt_q <= hit_cnt_q + 1'b1;
                end
            end
        end
    end

    // Result payload
    always_ff @(posedge clk_i) begin
        if (ev_fire) begin
            res_q.pc     <= ev_i.pc;
            res_q.kind   <= ev_i.kind;
            res_q.pred   <= pred;
            res_q.target <= ev_i.target;
            res_q.hit    <= hit;
        end
    end

    assign res_o       = res_q;
    assign res_valid_o = res_valid_q;
    assign ret_count_o = ret_cnt_q;
    assign hit_count_o = hit_cnt_q;

    // Stack top only moves on an accepted event
    a_ras_on_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !ev_fire |=> $stable(ras_top));

endmodule

//--- logic/sync_fifo.sv
// Synchronous FIFO with valid/ready on both ports, payload type set by the instantiating level
`include "rap_defs.svh"

module sync_fifo #(
    parameter type item_t = logic
) (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  item_t wr_data_i,
    input  logic  wr_valid_i,
    output logic  wr_ready_o,
    output item_t rd_data_o,
    output logic  rd_valid_o,
    input  logic  rd_ready_i
);

    localparam int DEPTH = `RAP_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];  // Storage, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic full;
    logic empty;
    logic wr_fire;
    logic rd_fire;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Full FIFO still takes a write when the head leaves this cycle
    assign wr_ready_o = !full || rd_ready_i;
    assign rd_valid_o = !empty;
    assign rd_data_o  = mem[rd_ptr];

    assign wr_fire = wr_valid_i && wr_ready_o;
    assign rd_fire = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_fire && !rd_fire) begin
                count <= count + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // A write into a full buffer leaves it exactly full
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        full && wr_fire |=> full);

    // Nothing leaves an empty buffer
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        empty && !wr_fire |=> empty);

endmodule

//--- tb/rap_trace.txt
# pc instr target kind pred hit, all hex, kind 0 call 1 return 2 swap
# a record that yields no result has -- after its target
0000001000 00008067 0000002000 1 0000000000 0
0000002000 000000ef 0000003000 0 0000003000 1
0000003010 000300e7 0000004000 0 0000004000 1
0000004020 000002ef 0000005000 0 0000005000 1
0000005000 00000013 0000005004 --
0000005004 00028067 0000004024 1 0000004024 1
0000004024 00030067 0000004100 --
0000004100 0000006f 0000004200 --
0000004200 00008067 0000003014 1 0000003014 1
0000003018 00008067 0000002004 1 0000002004 1
0000006000 000000ef 0000007000 0 0000007000 1
0000007000 000082e7 0000006004 2 0000006004 1
0000006004 000280e7 0000007004 2 0000007004 1
0000007008 00028067 0000006008 1 0000006008 1
0000008000 000080e7 0000009000 0 0000009000 1
0000009000 00008067 0000008004 1 0000008004 1
0000008004 00012083 0000008008 --
0000010000 000000ef 0000010100 0 0000010100 1
0000010100 000000ef 0000010200 0 0000010200 1
0000010200 000000ef 0000010300 0 0000010300 1
0000010300 000000ef 0000010400 0 0000010400 1
0000010400 000000ef 0000010500 0 0000010500 1
0000010500 000000ef 0000010600 0 0000010600 1
0000010600 000000ef 0000010700 0 0000010700 1
0000010700 000000ef 0000010800 0 0000010800 1
0000010800 000000ef 0000010900 0 0000010900 1
0000010900 000000ef 0000010a00 0 0000010a00 1
0000010a00 000000ef 0000010b00 0 0000010b00 1
0000010b00 000000ef 0000010c00 0 0000010c00 1
0000010c00 000000ef 0000010d00 0 0000010d00 1
0000010d00 000000ef 0000010e00 0 0000010e00 1
0000010e00 000000ef 0000010f00 0 0000010f00 1
0000010f00 000000ef 0000011000 0 0000011000 1
0000011000 000000ef 0000011100 0 0000011100 1
0000020000 00008067 0000011004 1 0000011004 1
0000020010 00008067 0000010f04 1 0000010f04 1
0000020020 00008067 0000010e04 1 0000010e04 1
0000020030 00008067 0000010d04 1 0000010d04 1
0000020040 00008067 0000010c04 1 0000010c04 1
0000020050 00008067 0000010b04 1 0000010b04 1
0000020060 00008067 0000010a04 1 0000010a04 1
0000020070 00008067 0000010904 1 0000010904 1
0000020080 00008067 0000010804 1 0000010804 1
0000020090 00008067 0000010704 1 0000010704 1
00000200a0 00008067 0000010604 1 0000010604 1
00000200b0 00008067 0000010504 1 0000010504 1
00000200c0 00008067 0000010404 1 0000010404 1
00000200d0 00008067 0000010304 1 0000010304 1
00000200e0 00008067 0000010204 1 0000010204 1
00000200f0 00008067 0000010104 1 0000010104 1
0000020100 00008067 0000010004 1 0000011004 0

//--- tb/tb_rap_top.sv
// Testbench for rap_top, replays the instruction trace with random stalls on both handshakes
module tb_rap_top;

    localparam string TRACE_FILE = "tb/rap_trace.txt";
    localparam int    TIMEOUT    = 500;  // Cycles allowed per wait

    logic                clk_i;
    logic                rstn_i;
    rap_pkg::instr_rec_t instr;
    logic                instr_valid;
    logic                instr_ready;
    rap_pkg::pred_res_t  res;
    logic                res_valid;
    logic                res_ready;
    logic [15:0]         ret_count;
    logic [15:0]         hit_count;

    rap_pkg::instr_rec_t recs [$];   // Stimulus in trace order
    rap_pkg::pred_res_t  exp_q [$];  // Expected results, oldest first
    int                  exp_rets;   // Returns and swaps in the trace
    int                  exp_hits;
    int                  n_checked;
    int                  value_errors;
    int                  other_failures;
    bit                  aborted;    // Set once the run cannot go on
    logic [31:0]         drv_state;
    logic [31:0]         sink_state;

    rap_top i_dut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .instr_ready_o (instr_ready),
        .res_o         (res),
        .res_valid_o   (res_valid),
        .res_ready_i   (res_ready),
        .ret_count_o   (ret_count),
        .hit_count_o   (hit_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // Period 8
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic finish_run;
        $display("Results checked: %0d, value errors: %0d, other failures: %0d",
                 n_checked, value_errors, other_failures);
        if (value_errors == 0 && other_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        other_failures++;
        $display("%s", why);
        aborted = 1'b1;
    endtask

    // Each data line gives a record, then kind, prediction and hit, or a drop marker
    task automatic load_trace;
        int                 fd;
        int                 n;
        string              line;
        string              tok;
        rap_pkg::addr_t     pc;
        rap_pkg::addr_t     tgt;
        rap_pkg::addr_t     pred;
        logic [31:0]        word;
        logic [1:0]         kind;
        logic               hit;
        rap_pkg::instr_rec_t rec;
        rap_pkg::pred_res_t want;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 4 || line.getc(0) == "#") begin
                    continue;  // Blank or column notes
                end
                n = $sscanf(line, "%h %h %h %s", pc, word, tgt, tok);
                if (n != 4) begin
                    abort_run({"Malformed trace line: ", line});
                    break;
                end
                rec.pc     = pc;
                rec.instr  = word;
                rec.target = tgt;
                recs.push_back(rec);
                if (tok != "--") begin
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                pc, word, tgt, kind, pred, hit);
                    if (n != 6) begin
                        abort_run({"Malformed trace line: ", line});
                        break;
                    end
                    want.pc     = pc;
                    want.kind   = rap_pkg::cf_kind_e'(kind);
                    want.pred   = pred;
                    want.target = tgt;
                    want.hit    = hit;
                    exp_q.push_back(want);
                    if (kind != 2'd0) begin  // Return or swap is scored
                        exp_rets++;
                        exp_hits += hit ? 1 : 0;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_result(input rap_pkg::pred_res_t got, input rap_pkg::pred_res_t want);
        n_checked++;
        if (got.pc !== want.pc) begin
            $display("Error: res_o.pc = %h, expected %h", got.pc, want.pc);
            value_errors++;
        end
        if (got.kind !== want.kind) begin
            $display("Error: res_o.kind = %h, expected %h", got.kind, want.kind);
            value_errors++;
        end
        if (got.pred !== want.pred) begin
            $display("Error: res_o.pred = %h, expected %h", got.pred, want.pred);
            value_errors++;
        end
        if (got.target !== want.target) begin
            $display("Error: res_o.target = %h, expected %h", got.target, want.target);
            value_errors++;
        end
        if (got.hit !== want.hit) begin
            $display("Error: res_o.hit = %h, expected %h", got.hit, want.hit);
            value_errors++;
        end
    endtask

    task automatic drive_records;
        int   waited;
        logic fired;
        foreach (recs[i]) begin
            if (aborted) begin
                break;
            end
            drv_state = lcg_next(drv_state);
            while (drv_state[17:16] == 2'd0) begin  // Random idle cycle
                @(posedge clk_i);
                #1;
                drv_state = lcg_next(drv_state);
            end
            instr       = recs[i];
            instr_valid = 1'b1;
            waited      = 0;
            fired       = 1'b0;
            while (!fired && !aborted) begin
                @(negedge clk_i);
                fired = instr_ready;  // Transfer on the coming edge
                @(posedge clk_i);
                #1;
                waited++;
                if (!fired && waited > TIMEOUT) begin
                    abort_run("Timed out waiting for instr_ready_o");
                end
            end
            instr_valid = 1'b0;
        end
    endtask

    task automatic sink_results;
        int idle;
        idle = 0;
        while (exp_q.size() > 0 && !aborted) begin
            sink_state = lcg_next(sink_state);
            res_ready  = sink_state[20];  // Back-pressure about half the time
            @(negedge clk_i);
            if (res_valid && res_ready) begin
                check_result(res, exp_q.pop_front());
                idle = 0;
            end else if (idle > TIMEOUT) begin
                abort_run("Timed out waiting for a result on res_o");
            end else begin
                idle++;
            end
            @(posedge clk_i);
            #1;
        end
        res_ready = 1'b0;
    endtask

    initial begin
        rstn_i      = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        res_ready   = 1'b0;
        drv_state   = 32'd41;
        sink_state  = 32'd41;
        aborted     = 1'b0;
        load_trace();
        repeat (16) @(posedge clk_i);
        #1 rstn_i = 1'b1;
        repeat (4) begin  // Idle after reset
            @(negedge clk_i);
            if (res_valid !== 1'b0) begin
                $display("Error: res_valid_o = %h, expected 0 after reset", res_valid);
                value_errors++;
            end
        end
        if (ret_count !== 16'h0 || hit_count !== 16'h0) begin
            $display("Error: ret_count_o = %h, hit_count_o = %h, expected 0",
                     ret_count, hit_count);
            value_errors++;
        end
        @(posedge clk_i);
        #1;
        fork
            drive_records();
            sink_results();
        join
        if (!aborted) begin
            res_ready = 1'b1;
            repeat (8) begin  // Nothing beyond the trace may appear
                @(negedge clk_i);
                if (res_valid) begin
                    $display("Error: res_valid_o = %h, expected 0 with no result left",
                             res_valid);
                    value_errors++;
                end
            end
            if (ret_count !== 16'(exp_rets)) begin
                $display("Error: ret_count_o = %h, expected %h", ret_count, 16'(exp_rets));
                value_errors++;
            end
            if (hit_count !== 16'(exp_hits)) begin
                $display("Error: hit_count_o = %h, expected %h", hit_count, 16'(exp_hits));
                value_errors++;
            end
        end
        finish_run();
    end

endmodule
